//--- hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and address width
`define CORE_DATA_WIDTH 32

// Instruction field widths
`define CORE_MICROOP_WIDTH 5
`define CORE_REG_ADDR_WIDTH 4
`define CORE_IMM_WIDTH 19

// Architectural register count
`define CORE_NUM_REGS (1 << `CORE_REG_ADDR_WIDTH)

// Input buffer entries
`define CORE_IBUF_DEPTH 2

`endif

//--- hdl/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // Micro-op codes, anything not listed retires as a no-op
    typedef enum logic [`CORE_MICROOP_WIDTH-1:0] {
        NOP   = 5'd0,
        ADD   = 5'd1,
        SUB   = 5'd2,
        AND   = 5'd3,
        XOR   = 5'd4,
        ADDI  = 5'd5,
        STORE = 5'd6
    } microop_e;

    typedef struct packed {
        microop_e                        microop;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_REG_ADDR_WIDTH-1:0] src1;
        logic [`CORE_REG_ADDR_WIDTH-1:0] src2;
        logic [14:0]                     unused;
    } reg_form_t;

    typedef struct packed {
        microop_e                        microop;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_REG_ADDR_WIDTH-1:0] src1;
        logic [`CORE_IMM_WIDTH-1:0]      imm;
    } imm_form_t;

    // One instruction word, two field layouts
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_word_u;

    typedef struct packed {
        logic                            valid;
        microop_e                        microop;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic                            write_en;
        logic [`CORE_DATA_WIDTH-1:0]     result;
        logic [`CORE_DATA_WIDTH-1:0]     store_addr;
    } exec_result_t;

    typedef struct packed {
        logic                            valid;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic                            write_en;
        logic [`CORE_DATA_WIDTH-1:0]     data;
    } commit_t;

    typedef struct packed {
        logic                        valid;
        logic [`CORE_DATA_WIDTH-1:0] addr;
        logic [`CORE_DATA_WIDTH-1:0] data;
        microop_e                    microop;
    } store_wb_t;

endpackage

`default_nettype wire

//--- hdl/instr_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module instr_buffer (
    input  wire logic                 clk,
    input  wire logic                 arst_n_i,
    input  wire logic                 in_valid_i,
    input  wire core_pkg::instr_word_u in_word_i,
    output logic                      in_ready_o,
    output logic                      out_valid_o,
    output core_pkg::instr_word_u     out_word_o,
    input  wire logic                 out_ready_i
);
    localparam int DEPTH = `CORE_IBUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    core_pkg::instr_word_u mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  push, pop;

    // Ready only looks at occupancy, so no path from out_ready_i
    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_word_o  = mem[rd_ptr_q];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_word_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module exec_stage (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  in_valid_i,
    input  wire core_pkg::instr_word_u in_word_i,
    output logic                       in_ready_o,
    input  wire logic                  stall_i,
    input  wire core_pkg::commit_t     wb_i,
    output core_pkg::exec_result_t     result_o
);
    localparam int DW = `CORE_DATA_WIDTH;
    localparam int RW = `CORE_REG_ADDR_WIDTH;
    localparam int IW = `CORE_IMM_WIDTH;

    logic [DW-1:0]      regs_q [`CORE_NUM_REGS];
    core_pkg::microop_e uop;
    logic [RW-1:0]      dest, src1, src2;
    logic [IW-1:0]      imm;
    logic [DW-1:0]      imm_ext, op_a, op_b, op_d, alu_res;
    logic               write_en;

    // Register read with bypass of the value sitting in retire
    function automatic logic [DW-1:0] read_operand(input logic [RW-1:0] idx);
        logic [DW-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_i.valid && wb_i.write_en && (wb_i.dest == idx)) begin
            val = wb_i.data;
        end else begin
            val = regs_q[idx];
        end
        return val;
    endfunction

    //////////////////////////////////////////////////
    // Decode
    assign uop  = in_word_i.reg_form.microop;
    assign dest = in_word_i.reg_form.dest;
    assign src1 = in_word_i.reg_form.src1;
    assign src2 = in_word_i.reg_form.src2;
    assign imm  = in_word_i.imm_form.imm;

    assign imm_ext = {{(DW - IW){imm[IW-1]}}, imm};

    always_comb begin
        op_a = read_operand(src1);
        op_b = read_operand(src2);
        // Store data comes from the dest field
        op_d = read_operand(dest);
    end

    //////////////////////////////////////////////////
    // ALU
    always_comb begin
        alu_res  = '0;
        write_en = 1'b1;
        case (uop)
            core_pkg::ADD:  alu_res = op_a + op_b;
            core_pkg::SUB:  alu_res = op_a - op_b;
            core_pkg::AND:  alu_res = op_a & op_b;
            core_pkg::XOR:  alu_res = op_a ^ op_b;
            core_pkg::ADDI: alu_res = op_a + imm_ext;
            default:        write_en = 1'b0;
        endcase
    end

    assign in_ready_o = ~stall_i;

    always_comb begin
        result_o.valid      = in_valid_i & ~stall_i;
        result_o.microop    = uop;
        result_o.dest       = dest;
        result_o.write_en   = write_en;
        result_o.result     = (uop == core_pkg::STORE) ? op_d : alu_res;
        result_o.store_addr = op_a + imm_ext;
    end

    //////////////////////////////////////////////////
    // Register file, r0 is never written
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.write_en && (wb_i.dest != '0)) begin
            regs_q[wb_i.dest] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  wire logic                   clk,
    input  wire logic                   arst_n_i,
    input  wire core_pkg::exec_result_t result_i,
    input  wire logic                   cache_blocked_i,
    output logic                        stall_o,
    output core_pkg::commit_t           wb_o,
    output core_pkg::commit_t           commit_o,
    output core_pkg::store_wb_t         store_o
);
    core_pkg::exec_result_t ret_q;
    logic                   is_store;
    logic                   retire_en;

    assign is_store = (ret_q.microop == core_pkg::STORE);

    // Only a store can be held back, and only by the cache
    assign stall_o   = ret_q.valid & is_store & cache_blocked_i;
    assign retire_en = ret_q.valid & ~stall_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ret_q <= '0;
        end else if (!stall_o) begin
            ret_q <= result_i;
        end
    end

    //////////////////////////////////////////////////
    // Commit and register write-back
    always_comb begin
        commit_o.valid    = retire_en;
        commit_o.dest     = ret_q.dest;
        commit_o.write_en = ret_q.write_en;
        commit_o.data     = ret_q.result;
    end

    // Same view goes back to execute for the write and bypass
    always_comb begin
        wb_o.valid    = retire_en;
        wb_o.dest     = ret_q.dest;
        wb_o.write_en = ret_q.write_en & retire_en;
        wb_o.data     = ret_q.result;
    end

    //////////////////////////////////////////////////
    // Store writeback to the data cache
    always_comb begin
        store_o.valid   = retire_en & is_store;
        store_o.addr    = ret_q.store_addr;
        store_o.data    = ret_q.result;
        store_o.microop = ret_q.microop;
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  instr_valid_i,
    input  wire core_pkg::instr_word_u instr_i,
    output logic                       instr_ready_o,
    input  wire logic                  cache_blocked_i,
    output core_pkg::commit_t          commit_o,
    output core_pkg::store_wb_t        store_o
);
    logic                   ib_valid, ex_ready, stall;
    core_pkg::instr_word_u  ib_word;
    core_pkg::exec_result_t ex_result;
    core_pkg::commit_t      wb;

    //////////////////////////////////////////////////
    // Input side
    instr_buffer i_instr_buffer (
        .clk        (clk          ),
        .arst_n_i   (arst_n_i     ),
        .in_valid_i (instr_valid_i),
        .in_word_i  (instr_i      ),
        .in_ready_o (instr_ready_o),
        .out_valid_o(ib_valid     ),
        .out_word_o (ib_word      ),
        .out_ready_i(ex_ready     )
    );

    //////////////////////////////////////////////////
    // Execute
    exec_stage i_exec_stage (
        .clk       (clk      ),
        .arst_n_i  (arst_n_i ),
        .in_valid_i(ib_valid ),
        .in_word_i (ib_word  ),
        .in_ready_o(ex_ready ),
        .stall_i   (stall    ),
        .wb_i      (wb       ),
        .result_o  (ex_result)
    );

    //////////////////////////////////////////////////
    // Output side
    retire_stage i_retire_stage (
        .clk            (clk            ),
        .arst_n_i       (arst_n_i       ),
        .result_i       (ex_result      ),
        .cache_blocked_i(cache_blocked_i),
        .stall_o        (stall          ),
        .wb_o           (wb             ),
        .commit_o       (commit_o       ),
        .store_o        (store_o        )
    );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);
    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held over the first two rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_checker (
    input  wire logic                  clk,
    input  wire logic                  arst_n_i,
    input  wire logic                  instr_valid_i,
    input  wire logic                  instr_ready_i,
    input  wire core_pkg::instr_word_u instr_i,
    input  wire core_pkg::commit_t     commit_i,
    input  wire core_pkg::store_wb_t   store_i,
    output int                         commit_count_o
);
    localparam int DW = `CORE_DATA_WIDTH;
    localparam int IW = `CORE_IMM_WIDTH;

    logic [DW-1:0]         model_regs [`CORE_NUM_REGS];
    core_pkg::instr_word_u pending [$];
    int                    accepted, committed, stores_seen, stores_expected, error_count;
    int                    checked [1:6];
    int                    failed [1:6];
    logic [3:0]            last_dest;
    logic                  last_write;
    bit                    instr_bad;

    assign commit_count_o = committed;

    initial begin
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int b = 1; b <= 6; b++) begin
            checked[b] = 0;
            failed[b]  = 0;
        end
        accepted        = 0;
        committed       = 0;
        stores_seen     = 0;
        stores_expected = 0;
        error_count     = 0;
        last_dest       = '0;
        last_write      = 1'b0;
    end

    task automatic compare(input string name, input logic [DW-1:0] expected,
                           input logic [DW-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            error_count++;
            instr_bad = 1'b1;
        end
    endtask

    task automatic fail_plain(input string what);
        $display("Failure at %0t: %s", $time, what);
        error_count++;
        instr_bad = 1'b1;
    endtask

    task automatic tally(input int beh);
        checked[beh]++;
        if (instr_bad) begin
            failed[beh]++;
        end
    endtask

    // Two buffer entries and the retire register hold every uncommitted instruction
    // Ready is high below two of them and low at three
    task automatic check_ready();
        int in_flight;
        in_flight = accepted - committed;
        instr_bad = 1'b0;
        if (in_flight <= 1) begin
            compare("instr_ready_o", 1'b1, instr_ready_i);
        end else if (in_flight >= 3) begin
            compare("instr_ready_o", 1'b0, instr_ready_i);
        end
        if (instr_bad) begin
            failed[6]++;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model, one instruction per commit
    task automatic check_commit();
        core_pkg::instr_word_u w;
        core_pkg::microop_e    uop;
        logic [3:0]            rd, rs1, rs2;
        logic [DW-1:0]         a, b, d, imm_ext, expected;
        logic                  write;
        bit                    dependent, uses_r0;
        int                    beh;
        instr_bad = 1'b0;
        if (pending.size() == 0) begin
            fail_plain("commit seen with no accepted instruction outstanding");
            failed[6]++;
            return;
        end
        w        = pending.pop_front();
        uop      = w.reg_form.microop;
        rd       = w.reg_form.dest;
        rs1      = w.reg_form.src1;
        rs2      = w.reg_form.src2;
        a        = (rs1 == '0) ? '0 : model_regs[rs1];
        b        = (rs2 == '0) ? '0 : model_regs[rs2];
        d        = (rd == '0) ? '0 : model_regs[rd];
        imm_ext  = DW'($signed(w.imm_form.imm));
        expected = '0;
        write    = 1'b1;
        beh      = 1;
        case (uop)
            core_pkg::ADD: expected = a + b;
            core_pkg::SUB: expected = a - b;
            core_pkg::AND: expected = a & b;
            core_pkg::XOR: expected = a ^ b;
            core_pkg::ADDI: begin
                expected = a + imm_ext;
                beh      = 2;
            end
            core_pkg::STORE: begin
                write = 1'b0;
                beh   = 4;
            end
            default: begin
                write = 1'b0;
                beh   = 5;
            end
        endcase
        // Reads of the register written by the previous instruction
        dependent = last_write && (last_dest != '0) && (beh != 5) &&
                    ((rs1 == last_dest) || (beh == 1 && rs2 == last_dest) ||
                     (beh == 4 && rd == last_dest));
        uses_r0 = (beh != 5) && ((rs1 == '0) || (beh == 1 && rs2 == '0) ||
                  (beh == 4 && rd == '0) || (write && rd == '0));
        compare("commit_o.dest", rd, commit_i.dest);
        compare("commit_o.write_en", write, commit_i.write_en);
        if (write) begin
            compare("commit_o.data", expected, commit_i.data);
        end
        if (beh == 4) begin
            stores_expected++;
            if (!store_i.valid) begin
                fail_plain("store committed without a store writeback");
            end else begin
                compare("store_o.addr", a + imm_ext, store_i.addr);
                compare("store_o.data", d, store_i.data);
                compare("store_o.microop", core_pkg::STORE, store_i.microop);
            end
        end else if (store_i.valid) begin
            fail_plain("store writeback for an instruction that is not a store");
        end
        if (write && rd != '0) begin
            model_regs[rd] = expected;
        end
        last_dest  = rd;
        last_write = write;
        tally(beh);
        if (dependent) begin
            tally(3);
        end
        if (uses_r0) begin
            tally(5);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n_i) begin
            check_ready();
            if (instr_valid_i && instr_ready_i) begin
                pending.push_back(instr_i);
                accepted++;
            end
            if (store_i.valid) begin
                stores_seen++;
            end
            if (commit_i.valid) begin
                committed++;
                check_commit();
            end else if (store_i.valid) begin
                fail_plain("store writeback seen without a commit");
            end
        end
    end

    task automatic print_line(input int beh, input string name);
        $display("Behavior %0d, %s: %0d checked, %0d failed",
                 beh, name, checked[beh], failed[beh]);
    endtask

    task automatic report(input int assert_fails, output int total_errors);
        if (committed != accepted) begin
            fail_plain($sformatf("%0d commits for %0d accepted instructions",
                                 committed, accepted));
            failed[6]++;
        end
        if (stores_seen != stores_expected) begin
            fail_plain($sformatf("%0d store writebacks for %0d stores",
                                 stores_seen, stores_expected));
            failed[4]++;
        end
        checked[6] = committed;
        print_line(1, "register ALU ops");
        print_line(2, "ADDI sign extension");
        print_line(3, "forwarded dependents");
        print_line(4, "store writebacks");
        print_line(5, "register 0 and unknown ops");
        print_line(6, "commit count");
        $display("Totals: %0d accepted, %0d committed, %0d stores, %0d errors, %0d assert fails",
                 accepted, committed, stores_seen, error_count, assert_fails);
        total_errors = error_count + assert_fails;
    endtask

endmodule

`default_nettype wire

//--- verification/core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module core_asserts (
    input wire logic                clk,
    input wire logic                arst_n_i,
    input wire logic                cache_blocked_i,
    input wire core_pkg::commit_t   commit_i,
    input wire core_pkg::store_wb_t store_i
);
    int fail_count = 0;

    // A blocked cache must see no store writeback
    store_while_blocked: assert property (
        @(posedge clk) disable iff (!arst_n_i) cache_blocked_i |-> !store_i.valid
    ) else begin
        fail_count++;
        $error("store writeback issued while the cache is blocked");
    end

    commit_in_reset: assert property (
        @(posedge clk) !arst_n_i |-> !commit_i.valid
    ) else begin
        fail_count++;
        $error("commit valid during reset");
    end

    // Every store goes out together with its commit
    store_without_commit: assert property (
        @(posedge clk) disable iff (!arst_n_i) store_i.valid |-> commit_i.valid
    ) else begin
        fail_count++;
        $error("store writeback without a commit in the same cycle");
    end

endmodule

`default_nettype wire

//--- verification/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 20 + 100;

    logic                  clk, arst_n;
    logic                  instr_valid, instr_ready, cache_blocked;
    core_pkg::instr_word_u instr;
    core_pkg::commit_t     commit;
    core_pkg::store_wb_t   store;
    int                    commit_count;
    int                    cycle_count;

    bind core_top core_asserts i_core_asserts (
        .clk            (clk            ),
        .arst_n_i       (arst_n_i       ),
        .cache_blocked_i(cache_blocked_i),
        .commit_i       (commit_o       ),
        .store_i        (store_o        )
    );

    tb_clock i_tb_clock (
        .clk_o   (clk   ),
        .arst_n_o(arst_n)
    );

    core_top i_core_top (
        .clk            (clk          ),
        .arst_n_i       (arst_n       ),
        .instr_valid_i  (instr_valid  ),
        .instr_i        (instr        ),
        .instr_ready_o  (instr_ready  ),
        .cache_blocked_i(cache_blocked),
        .commit_o       (commit       ),
        .store_o        (store        )
    );

    core_checker i_core_checker (
        .clk           (clk         ),
        .arst_n_i      (arst_n      ),
        .instr_valid_i (instr_valid ),
        .instr_ready_i (instr_ready ),
        .instr_i       (instr       ),
        .commit_i      (commit      ),
        .store_i       (store       ),
        .commit_count_o(commit_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic core_pkg::instr_word_u build_word(input logic [31:0] r1,
                                                         input logic [31:0] r2);
        core_pkg::instr_word_u w;
        logic [4:0]            code;
        // Mostly defined codes, now and then any 5-bit value
        if (r1[31:28] < 4'd13) begin
            code = 5'(r1[27:20] % 8'd7);
        end else begin
            code = r1[24:20];
        end
        w.reg_form.microop = core_pkg::microop_e'(code);
        w.reg_form.dest    = r2[31:28];
        w.reg_form.src1    = r2[27:24];
        w.imm_form.imm     = r2[18:0];
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] seed, r0, r1, r2;
        int          sent, block_left, errors;
        seed          = 32'hf249;
        sent          = 0;
        block_left    = 0;
        instr_valid   <= 1'b0;
        instr         <= '0;
        cache_blocked <= 1'b0;
        @(posedge arst_n);
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            if (instr_valid && instr_ready) begin
                sent++;
            end
            seed = lcg_next(seed);
            r0   = seed;
            seed = lcg_next(seed);
            r1   = seed;
            seed = lcg_next(seed);
            r2   = seed;
            // Random blocking plus occasional long bursts to fill the buffer
            if (block_left > 0) begin
                block_left--;
                cache_blocked <= 1'b1;
            end else if (r0[29:25] == 5'd0) begin
                block_left = 3 + int'(r0[24:22]);
                cache_blocked <= 1'b1;
            end else begin
                cache_blocked <= (r0[21:20] == 2'd0);
            end
            if (!instr_valid || instr_ready) begin
                if (sent < NUM_INSTR && r0[31:30] != 2'd0) begin
                    instr_valid <= 1'b1;
                    instr       <= build_word(r1, r2);
                end else begin
                    instr_valid <= 1'b0;
                end
            end
        end
        cache_blocked <= 1'b0;
        while (commit_count < NUM_INSTR) begin
            @(posedge clk);
        end
        // Extra cycles to catch duplicated commits
        repeat (10) @(posedge clk);
        i_core_checker.report(i_core_top.i_core_asserts.fail_count, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count <= MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, only %0d of %0d instructions committed",
                 cycle_count, commit_count, NUM_INSTR);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_buffer.sv
hdl/exec_stage.sv
hdl/retire_stage.sv
hdl/core_top.sv
verification/tb_clock.sv
verification/core_checker.sv
verification/core_asserts.sv
verification/tb_core.sv

//--- Bender.yml
package:
  name: core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/core_pkg.sv
      - hdl/instr_buffer.sv
      - hdl/exec_stage.sv
      - hdl/retire_stage.sv
      - hdl/core_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_clock.sv
      - verification/core_checker.sv
      - verification/core_asserts.sv
      - verification/tb_core.sv
